//--- src/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction formats for the load/store path,
// imported by the decode stage and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

  // major opcodes handled by this path
  localparam logic [6:0] opcode_load  = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  typedef logic [2:0] funct3_t;

  // load widths
  localparam funct3_t funct3_lb  = 3'b000;
  localparam funct3_t funct3_lh  = 3'b001;
  localparam funct3_t funct3_lw  = 3'b010;
  localparam funct3_t funct3_lbu = 3'b100;
  localparam funct3_t funct3_lhu = 3'b101;

  // store widths
  localparam funct3_t funct3_sb = 3'b000;
  localparam funct3_t funct3_sh = 3'b001;
  localparam funct3_t funct3_sw = 3'b010;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    funct3_t     funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  // immediate split around rs2 and rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_t    funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } stype_t;

  // one word, read as I-type for loads and S-type for stores
  typedef union packed {
    itype_t i;
    stype_t s;
  } instr_u;

endpackage

//--- src/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory operation, request and result types
// shared by all load/store stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

  typedef enum logic [1:0] {
    BYTE     = 2'd0,
    HALFWORD = 2'd1,
    WORD     = 2'd2
  } mem_width_t;

  // decoded operation, registered by the decode stage
  typedef struct packed {
    logic              valid;
    logic              is_store;
    mem_width_t        width;
    logic              sign_extend;
    logic [4:0]        rd;
    logic [31:0]       base;
    logic signed [11:0] offset;
  } mem_op_t;

  // address kept at 32 bits, the memory uses the low part
  typedef struct packed {
    logic        valid;
    logic        write_enable;
    mem_width_t  width;
    logic        sign_extend;
    logic [4:0]  rd;
    logic [31:0] address;
    logic [31:0] data;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  typedef enum logic [1:0] {
    NONE       = 2'd0,
    MISALIGNED = 2'd1,
    ILLEGAL    = 2'd2
  } fault_kind_t;

  typedef struct packed {
    logic        valid;
    fault_kind_t kind;
  } fault_t;

endpackage

//--- src/lsu_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first stage, registers an instruction and turns
// it into a memory operation or an illegal flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_decode
  import isa_pkg::*;
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  instr_u      instr,
  input  logic [31:0] rs1_value,
  input  logic [31:0] rs2_value,
  output mem_op_t     op,
  output logic [31:0] store_data,
  output logic        illegal
);

  mem_op_t op_next;
  logic    legal;

  always_comb begin
    op_next = '0;
    legal = 1'b0;
    op_next.base = rs1_value;
    case (instr.i.opcode)
      opcode_load: begin
        op_next.rd = instr.i.rd;
        op_next.offset = instr.i.imm;
        legal = 1'b1;
        case (instr.i.funct3)
          funct3_lb: begin
            op_next.width = BYTE;
            op_next.sign_extend = 1'b1;
          end
          funct3_lh: begin
            op_next.width = HALFWORD;
            op_next.sign_extend = 1'b1;
          end
          funct3_lw:  op_next.width = WORD;
          funct3_lbu: op_next.width = BYTE;
          funct3_lhu: op_next.width = HALFWORD;
          default:    legal = 1'b0;
        endcase
      end
      opcode_store: begin
        // rd stays 0, the rd bits hold imm[4:0] here
        op_next.is_store = 1'b1;
        op_next.offset = {instr.s.imm_hi, instr.s.imm_lo};
        legal = 1'b1;
        case (instr.s.funct3)
          funct3_sb: op_next.width = BYTE;
          funct3_sh: op_next.width = HALFWORD;
          funct3_sw: op_next.width = WORD;
          default:   legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    op_next.valid = instr_valid && legal;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
      illegal <= 1'b0;
    end else begin
      op <= op_next;
      illegal <= instr_valid && !legal;
    end
    store_data <= rs2_value;
  end

endmodule

//--- src/lsu_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address stage, combinational, feeds the data
// memory and the result stage in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_execute
  import mem_pkg::*;
(
  input  mem_op_t     op,
  input  logic [31:0] store_data,
  output mem_req_t    req
);

  logic [31:0] offset_ext;

  // 12-bit immediate widened to the address size
  assign offset_ext = {{20{op.offset[11]}}, op.offset};

  always_comb begin
    req.valid = op.valid;
    req.write_enable = op.valid && op.is_store;
    req.width = op.width;
    req.sign_extend = op.sign_extend;
    req.rd = op.rd;
    req.address = op.base + offset_ext;
    req.data = store_data;
  end

endmodule

//--- src/data_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte addressed data memory, lane writes on the
// clock edge and combinational sized reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module data_mem
  import mem_pkg::*;
#(
  parameter int MemSize = 4096
) (
  input  logic        clk,
  input  mem_req_t    req,
  output logic [31:0] data_out,
  output logic        alignment_error
);

  localparam int AddrWidth = $clog2(MemSize);
  localparam int Words = MemSize / 4;

  logic [3:0][7:0] mem [Words];

  logic [AddrWidth-3:0] word_index;
  logic [1:0]           lane;
  logic [3:0]           lane_en;
  logic [3:0][7:0]      write_word;
  logic [3:0][7:0]      read_word;
  logic [7:0]           byte_val;
  logic [15:0]          half_val;

  assign word_index = req.address[AddrWidth-1:2];
  assign lane = req.address[1:0];

  // store data replicated so each lane finds its byte in place
  always_comb begin
    case (req.width)
      BYTE: begin
        lane_en = 4'b0001 << lane;
        write_word = {4{req.data[7:0]}};
      end
      HALFWORD: begin
        // lane pair from bit 1, written even when bit 0 is set
        lane_en = lane[1] ? 4'b1100 : 4'b0011;
        write_word = {2{req.data[15:0]}};
      end
      WORD: begin
        lane_en = 4'b1111;
        write_word = req.data;
      end
      default: begin
        lane_en = 4'b0000;
        write_word = req.data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (req.write_enable && lane_en[i]) begin
        mem[word_index][i] <= write_word[i];
      end
    end
  end

  always_comb begin
    read_word = mem[word_index];
    byte_val = read_word[lane];
    half_val = {read_word[{lane[1], 1'b1}], read_word[{lane[1], 1'b0}]};
    case (req.width)
      BYTE: begin
        alignment_error = 1'b0;
        data_out = {{24{byte_val[7] & req.sign_extend}}, byte_val};
      end
      HALFWORD: begin
        alignment_error = lane[0];
        data_out = {{16{half_val[15] & req.sign_extend}}, half_val};
      end
      WORD: begin
        alignment_error = (lane != 2'b00);
        data_out = read_word;
      end
      default: begin
        alignment_error = 1'b0;
        data_out = '0;
      end
    endcase
  end

  a_width_legal: assert property (
    @(posedge clk) req.valid |-> req.width inside {BYTE, HALFWORD, WORD}
  ) else $error("request width out of range");

endmodule

//--- src/lsu_result.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// last stage, registers the load writeback or the
// fault for the request in execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_result
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  mem_req_t    req,
  input  logic        illegal,
  input  logic [31:0] data_out,
  input  logic        alignment_error,
  output wb_t         wb,
  output fault_t      fault
);

  wb_t    wb_next;
  fault_t fault_next;
  logic   misaligned;

  assign misaligned = req.valid && alignment_error;

  always_comb begin
    wb_next = '0;
    fault_next = '0;
    if (illegal) begin
      fault_next.valid = 1'b1;
      fault_next.kind = ILLEGAL;
    end else if (misaligned) begin
      // a store lands here too, its lanes are already written
      fault_next.valid = 1'b1;
      fault_next.kind = MISALIGNED;
    end else if (req.valid && !req.write_enable && req.rd != 5'd0) begin
      wb_next.valid = 1'b1;
      wb_next.rd = req.rd;
      wb_next.data = data_out;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.valid <= 1'b0;
      fault <= '0;
    end else begin
      wb <= wb_next;
      fault <= fault_next;
    end
  end

  // decode never flags an illegal op in a live slot
  a_illegal_not_valid: assert property (
    @(posedge clk) disable iff (!rst_n) !(illegal && req.valid)
  ) else $error("illegal op arrived with a valid request");

endmodule

//--- src/lsu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store path top, decode then execute with the
// data memory then result, two cycles end to end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_top
  import isa_pkg::*;
  import mem_pkg::*;
#(
  parameter int MemSize = 4096
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  instr_u      instr,
  input  logic [31:0] rs1_value,
  input  logic [31:0] rs2_value,
  output wb_t         wb,
  output fault_t      fault
);

  mem_op_t     op;
  logic [31:0] store_data;
  logic        illegal;
  mem_req_t    req;
  logic [31:0] data_out;
  logic        alignment_error;

  lsu_decode lsu_decode_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .op          (op),
    .store_data  (store_data),
    .illegal     (illegal)
  );

  lsu_execute lsu_execute_inst (
    .op         (op),
    .store_data (store_data),
    .req        (req)
  );

  data_mem #(
    .MemSize (MemSize)
  ) data_mem_inst (
    .clk             (clk),
    .req             (req),
    .data_out        (data_out),
    .alignment_error (alignment_error)
  );

  lsu_result lsu_result_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req),
    .illegal         (illegal),
    .data_out        (data_out),
    .alignment_error (alignment_error),
    .wb              (wb),
    .fault           (fault)
  );

endmodule

//--- sim/lsu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table driven testbench for the load/store path,
// expected results come from a byte array model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_tb
  import isa_pkg::*;
  import mem_pkg::*;
;

  localparam int MemSize = 4096;
  localparam int RandomRows = 200;
  localparam logic [31:0] WindowBase = 32'h100;

  typedef enum logic [1:0] {
    KIND_LOAD,
    KIND_STORE,
    KIND_OTHER
  } kind_t;

  typedef struct packed {
    logic        valid;
    kind_t       kind;
    funct3_t     funct3;
    logic [4:0]  rd;
    logic [11:0] offset;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    wb_t         exp_wb;
    fault_t      exp_fault;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  instr_u      instr;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  wb_t         wb;
  fault_t      fault;

  logic [7:0]  ref_mem [MemSize];
  row_t        rows [$];
  logic [31:0] rng;
  int          wb_errors = 0;
  int          fault_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 1000000;

  lsu_top #(
    .MemSize (MemSize)
  ) lsu_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .wb          (wb),
    .fault       (fault)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // standard RV32I encodings, OP-IMM stands in for any other opcode
  function automatic instr_u encode(input row_t r);
    instr_u word;
    case (r.kind)
      KIND_LOAD: word = {r.offset, 5'd1, r.funct3, r.rd, opcode_load};
      KIND_STORE: word = {r.offset[11:5], 5'd2, 5'd1, r.funct3, r.offset[4:0], opcode_store};
      default: word = {r.offset, 5'd1, r.funct3, r.rd, 7'b0010011};
    endcase
    return word;
  endfunction

  // program order model of one instruction
  task automatic model_row(inout row_t r);
    logic [31:0] addr;
    logic [31:0] a;
    logic [31:0] base;
    logic        legal;
    logic        misaligned;
    logic [31:0] value;
    int          k;
    r.exp_wb = '0;
    r.exp_fault = '0;
    addr = r.rs1_value + {{20{r.offset[11]}}, r.offset};
    a = addr & (MemSize - 1);
    case (r.kind)
      KIND_LOAD: legal = r.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      KIND_STORE: legal = r.funct3 inside {3'd0, 3'd1, 3'd2};
      default: legal = 1'b0;
    endcase
    misaligned = (r.funct3[1:0] == 2'd1 && a[0]) ||
                 (r.funct3[1:0] == 2'd2 && a[1:0] != 2'b00);
    if (!r.valid) begin
      // an idle slot leaves memory alone and expects nothing
    end else if (!legal) begin
      r.exp_fault.valid = 1'b1;
      r.exp_fault.kind = ILLEGAL;
    end else if (r.kind == KIND_STORE) begin
      // misaligned stores still land in the aligned lanes
      case (r.funct3[1:0])
        2'd0: ref_mem[a] = r.rs2_value[7:0];
        2'd1: begin
          base = {a[31:2], a[1], 1'b0};
          ref_mem[base] = r.rs2_value[7:0];
          ref_mem[base + 1] = r.rs2_value[15:8];
        end
        default: begin
          base = {a[31:2], 2'b00};
          for (k = 0; k < 4; k++) begin
            ref_mem[base + k] = r.rs2_value[8*k +: 8];
          end
        end
      endcase
      if (misaligned) begin
        r.exp_fault.valid = 1'b1;
        r.exp_fault.kind = MISALIGNED;
      end
    end else if (misaligned) begin
      r.exp_fault.valid = 1'b1;
      r.exp_fault.kind = MISALIGNED;
    end else begin
      case (r.funct3[1:0])
        2'd0: value = {{24{ref_mem[a][7] & ~r.funct3[2]}}, ref_mem[a]};
        2'd1: value = {{16{ref_mem[a + 1][7] & ~r.funct3[2]}}, ref_mem[a + 1], ref_mem[a]};
        default: value = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
      endcase
      if (r.rd != 5'd0) begin
        r.exp_wb.valid = 1'b1;
        r.exp_wb.rd = r.rd;
        r.exp_wb.data = value;
      end
    end
  endtask

  task automatic add_row(input logic valid, input kind_t kind, input funct3_t funct3,
                         input logic [4:0] rd, input logic [11:0] offset,
                         input logic [31:0] rs1, input logic [31:0] rs2);
    row_t r;
    r = '0;
    r.valid = valid;
    r.kind = kind;
    r.funct3 = funct3;
    r.rd = rd;
    r.offset = offset;
    r.rs1_value = rs1;
    r.rs2_value = rs2;
    model_row(r);
    rows.push_back(r);
  endtask

  task automatic add_directed_rows();
    // word round trip, the load follows the store at once
    add_row(1'b1, KIND_STORE, funct3_sw, 5'd0, 12'h000, 32'h200, 32'hdeadbeef);
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd5, 12'h000, 32'h200, 32'h0);
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd6, 12'hff0, 32'h210, 32'h0);
    // byte and halfword lanes with both extensions
    add_row(1'b1, KIND_STORE, funct3_sw, 5'd0, 12'h004, 32'h200, 32'h0);
    add_row(1'b1, KIND_STORE, funct3_sb, 5'd0, 12'h005, 32'h200, 32'h12345680);
    add_row(1'b1, KIND_LOAD, funct3_lb, 5'd7, 12'h005, 32'h200, 32'h0);
    add_row(1'b1, KIND_LOAD, funct3_lbu, 5'd8, 12'h005, 32'h200, 32'h0);
    add_row(1'b1, KIND_STORE, funct3_sh, 5'd0, 12'h006, 32'h200, 32'h9999f00d);
    add_row(1'b1, KIND_LOAD, funct3_lh, 5'd9, 12'h006, 32'h200, 32'h0);
    add_row(1'b1, KIND_LOAD, funct3_lhu, 5'd10, 12'h006, 32'h200, 32'h0);
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd11, 12'h004, 32'h200, 32'h0);
    // misaligned accesses
    add_row(1'b1, KIND_LOAD, funct3_lh, 5'd12, 12'h001, 32'h200, 32'h0);
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd13, 12'h002, 32'h200, 32'h0);
    add_row(1'b1, KIND_STORE, funct3_sw, 5'd0, 12'h008, 32'h200, 32'h11223344);
    add_row(1'b1, KIND_STORE, funct3_sh, 5'd0, 12'h00b, 32'h200, 32'h0000abcd);
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd14, 12'h008, 32'h200, 32'h0);
    // illegal encodings leave memory alone
    add_row(1'b1, KIND_OTHER, 3'b000, 5'd15, 12'h008, 32'h200, 32'h0);
    add_row(1'b1, KIND_LOAD, 3'b011, 5'd16, 12'h008, 32'h200, 32'h0);
    add_row(1'b1, KIND_STORE, 3'b011, 5'd0, 12'h008, 32'h200, 32'hffffffff);
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd17, 12'h008, 32'h200, 32'h0);
    // load into x0, then an idle slot
    add_row(1'b1, KIND_LOAD, funct3_lw, 5'd0, 12'h000, 32'h200, 32'h0);
    add_row(1'b0, KIND_LOAD, funct3_lw, 5'd18, 12'h000, 32'h200, 32'h0);
  endtask

  task automatic add_random_rows();
    logic [31:0] addr;
    logic [11:0] offset;
    logic [3:0]  sel;
    logic [4:0]  rd;
    logic [31:0] data;
    funct3_t     f3;
    int          i;
    // fill the random window first so every load reads known bytes
    for (i = 0; i < 16; i++) begin
      rng = lcg_next(rng);
      add_row(1'b1, KIND_STORE, funct3_sw, 5'd0, 12'h000, WindowBase + 32'(4 * i), rng);
    end
    for (i = 0; i < RandomRows; i++) begin
      rng = lcg_next(rng);
      sel = rng[31:28];
      addr = WindowBase + {26'd0, rng[21:16]};
      rng = lcg_next(rng);
      offset = rng[27:16];
      rng = lcg_next(rng);
      rd = rng[20:16];
      f3 = rng[24:22];
      data = lcg_next(rng);
      rng = data;
      addr = addr - {{20{offset[11]}}, offset};
      if (sel <= 4'd6) begin
        if (f3 inside {3'd3, 3'd6, 3'd7}) begin
          f3 = funct3_lw;
        end
        add_row(1'b1, KIND_LOAD, f3, rd, offset, addr, data);
      end else if (sel <= 4'd12) begin
        f3 = (f3[1:0] == 2'd3) ? funct3_sw : {1'b0, f3[1:0]};
        add_row(1'b1, KIND_STORE, f3, 5'd0, offset, addr, data);
      end else if (sel == 4'd13) begin
        add_row(1'b1, KIND_OTHER, f3, rd, offset, addr, data);
      end else if (sel == 4'd14) begin
        if (data[0]) begin
          add_row(1'b1, KIND_LOAD, f3[0] ? 3'd3 : {2'b11, f3[1]}, rd, offset, addr, data);
        end else begin
          add_row(1'b1, KIND_STORE, {1'b1, f3[1:0]}, 5'd0, offset, addr, data);
        end
      end else begin
        add_row(1'b0, KIND_LOAD, f3, rd, offset, addr, data);
      end
    end
  endtask

  task automatic drive_row(input row_t r);
    instr_valid <= r.valid;
    instr <= encode(r);
    rs1_value <= r.rs1_value;
    rs2_value <= r.rs2_value;
  endtask

  task automatic check_wb(input wb_t got, input wb_t exp, input int row);
    if (got.valid !== exp.valid) begin
      $display("Fail %0t: row %0d wb.valid is %b, expected %b", $time, row, got.valid,
               exp.valid);
      wb_errors++;
    end else if (exp.valid && (got.rd !== exp.rd || got.data !== exp.data)) begin
      $display("Fail %0t: row %0d wb rd %0d data %h, expected rd %0d data %h", $time, row,
               got.rd, got.data, exp.rd, exp.data);
      wb_errors++;
    end
  endtask

  task automatic check_fault(input fault_t got, input fault_t exp, input int row);
    if (got.valid !== exp.valid || (exp.valid && got.kind !== exp.kind)) begin
      $display("Fail %0t: row %0d fault valid %b kind %s, expected valid %b kind %s",
               $time, row, got.valid, got.kind.name(), exp.valid, exp.kind.name());
      fault_errors++;
    end
  endtask

  initial begin
    int n;
    clk = 1'b0;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    rs1_value = '0;
    rs2_value = '0;
    rng = 32'h14be912f;
    add_directed_rows();
    add_random_rows();
    n = rows.size();
    cycle_limit = n + 20;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // a row's result shows two edges after the edge that drives it
    for (int c = 0; c < n + 2; c++) begin
      @(posedge clk);
      if (c < n) begin
        drive_row(rows[c]);
      end else begin
        instr_valid <= 1'b0;
      end
      @(negedge clk);
      if (c >= 2) begin
        check_wb(wb, rows[c - 2].exp_wb, c - 2);
        check_fault(fault, rows[c - 2].exp_fault, c - 2);
      end
    end

    $display("rows: %0d, wb errors: %0d, fault errors: %0d", n, wb_errors, fault_errors);
    if (wb_errors == 0 && fault_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- sources.f
src/isa_pkg.sv
src/mem_pkg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/data_mem.sv
src/lsu_result.sv
src/lsu_top.sv
sim/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lsu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
